//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_stitch
FILELIST  ?= files.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+verilog
verilog/stitch_pkg.sv
verilog/cam_capture.sv
verilog/video_timing_gen.sv
verilog/stitch_readout.sv
verilog/video_stitch_top.sv
test/tb_video_stitch.sv

//--- test/tb_video_stitch.sv
`timescale 1ns/1ns
`include "stitch_macros.svh"

module tb_video_stitch;

    localparam int FRAME_CLKS     = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = 14 * FRAME_CLKS;

    logic               video_clk;
    logic               rst_n;
    logic               cam_vsync [`NUM_CAM];
    logic               cam_href  [`NUM_CAM];
    logic               cam_clken [`NUM_CAM];
    logic [`PIX_W-1:0]  cam_data  [`NUM_CAM];
    logic               video_vsync;
    logic               video_href;
    logic               video_de;
    logic [`PIX_W-1:0]  video_data;

    // mirror of each frame store and its ready flag
    logic [`PIX_W-1:0]  model_mem   [`NUM_CAM][`CAM_PIX];
    logic               model_ready [`NUM_CAM];

    logic [15:0]        lfsr;
    string              cur_test;
    int                 cycle_count;
    int                 frames_done;
    int                 vs_periods;
    int                 test_errors;
    int                 err_count;
    int                 check_count;
    int                 test_count;
    int                 failed_tests;

    video_stitch_top uut (
          .video_clk   (video_clk)
        , .rst_n       (rst_n)
        , .cmos0_vsync (cam_vsync[0])
        , .cmos0_href  (cam_href[0])
        , .cmos0_clken (cam_clken[0])
        , .cmos0_data  (cam_data[0])
        , .cmos1_vsync (cam_vsync[1])
        , .cmos1_href  (cam_href[1])
        , .cmos1_clken (cam_clken[1])
        , .cmos1_data  (cam_data[1])
        , .cmos2_vsync (cam_vsync[2])
        , .cmos2_href  (cam_href[2])
        , .cmos2_clken (cam_clken[2])
        , .cmos2_data  (cam_data[2])
        , .video_vsync (video_vsync)
        , .video_href  (video_href)
        , .video_de    (video_de)
        , .video_data  (video_data)
    );

    initial begin
        video_clk = 1'b0;
        forever #10 video_clk = ~video_clk;
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    task automatic next_pixel(output logic [`PIX_W-1:0] pix);
        pix = '0;
        for (int b = 0; b < `PIX_W; b++) begin
            pix  = {pix[`PIX_W-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // display column x comes from camera x / CAM_H and stays black until its frame is complete
    function automatic logic [`PIX_W-1:0] expected_pixel(input int x, input int y);
        int cam;
        int col;
        cam = x / `CAM_H;
        col = x % `CAM_H;
        if (!model_ready[cam]) begin
            return '0;
        end
        return model_mem[cam][y * `CAM_H + col];
    endfunction

    // one frame on every camera in mask in lockstep
    task automatic send_frames(input logic [`NUM_CAM-1:0] mask, input int rows);
        logic [`PIX_W-1:0] pix;
        repeat (2) @(negedge video_clk);
        for (int i = 0; i < `NUM_CAM; i++) begin
            if (mask[i]) cam_vsync[i] = 1'b0;
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < `CAM_H; c++) begin
                @(negedge video_clk);
                for (int i = 0; i < `NUM_CAM; i++) begin
                    if (mask[i]) begin
                        next_pixel(pix);
                        cam_href[i]  = 1'b1;
                        cam_clken[i] = 1'b1;
                        cam_data[i]  = pix;
                        model_mem[i][r * `CAM_H + c] = pix;
                    end
                end
            end
            @(negedge video_clk);
            for (int i = 0; i < `NUM_CAM; i++) begin
                if (mask[i]) begin
                    cam_href[i]  = 1'b0;
                    cam_clken[i] = 1'b0;
                end
            end
        end
        @(negedge video_clk);
        for (int i = 0; i < `NUM_CAM; i++) begin
            if (mask[i]) cam_vsync[i] = 1'b1;
        end
        repeat (2) @(negedge video_clk);
        for (int i = 0; i < `NUM_CAM; i++) begin
            if (mask[i] && rows == `CAM_V) model_ready[i] = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic report_test();
        test_count++;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic wait_output_frame();
        int n;
        n = frames_done;
        wait (frames_done > n);
    endtask

    // compares every output pixel and the sync timing on the falling edge
    initial begin
        int  px;
        int  py;
        int  de_cnt;
        int  line_cnt;
        int  last_vs;
        int  last_hs;
        logic prev_vs;
        logic prev_hs;
        logic [`PIX_W-1:0] exp_pix;
        px = 0;
        py = 0;
        de_cnt = 0;
        line_cnt = 0;
        last_vs = -1;
        last_hs = -1;
        prev_vs = 1'b0;
        prev_hs = 1'b0;
        forever begin
            @(negedge video_clk);
            if (video_vsync && !prev_vs) begin
                if (last_vs >= 0 && cycle_count - last_vs != FRAME_CLKS) begin
                    $display("[ERROR] %s vsync period expected %0d actual %0d",
                             cur_test, FRAME_CLKS, cycle_count - last_vs);
                    test_errors++;
                    err_count++;
                end
                if (last_vs >= 0) vs_periods++;
                if (last_vs >= 0 && py != `V_DISP) begin
                    $display("[ERROR] %s active lines per frame expected %0d actual %0d",
                             cur_test, `V_DISP, py);
                    test_errors++;
                    err_count++;
                end
                last_vs = cycle_count;
                py = 0;
            end
            if (video_href && !prev_hs) begin
                if (last_hs >= 0 && cycle_count - last_hs != `H_TOTAL) begin
                    $display("[ERROR] %s href period expected %0d actual %0d",
                             cur_test, `H_TOTAL, cycle_count - last_hs);
                    test_errors++;
                    err_count++;
                end
                last_hs = cycle_count;
            end
            prev_vs = video_vsync;
            prev_hs = video_href;
            if (video_de) begin
                exp_pix = expected_pixel(px, py);
                check_count++;
                if (video_data !== exp_pix) begin
                    $display("[ERROR] %s pixel (%0d,%0d) expected %06h actual %06h",
                             cur_test, px, py, exp_pix, video_data);
                    test_errors++;
                    err_count++;
                end
                px++;
                de_cnt++;
            end else begin
                if (video_data !== '0) begin
                    $display("[ERROR] %s video_data while de is low expected 000000 actual %06h",
                             cur_test, video_data);
                    test_errors++;
                    err_count++;
                end
                if (de_cnt != 0) begin
                    if (de_cnt != `H_DISP) begin
                        $display("[ERROR] %s de clocks per line expected %0d actual %0d",
                                 cur_test, `H_DISP, de_cnt);
                        test_errors++;
                        err_count++;
                    end
                    de_cnt = 0;
                    px = 0;
                    py++;
                    line_cnt++;
                    if (line_cnt == `V_DISP) begin
                        line_cnt = 0;
                        frames_done++;
                    end
                end
            end
        end
    end

    // run limit of whole output frames
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge video_clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d clocks", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        lfsr = 16'd5;
        frames_done = 0;
        vs_periods = 0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        failed_tests = 0;
        rst_n = 1'b0;
        for (int i = 0; i < `NUM_CAM; i++) begin
            cam_vsync[i]   = 1'b1;
            cam_href[i]    = 1'b0;
            cam_clken[i]   = 1'b0;
            cam_data[i]    = '0;
            model_ready[i] = 1'b0;
        end

        begin_test("reset_state");
        repeat (2) begin
            @(negedge video_clk);
            if (video_vsync !== 1'b0 || video_href !== 1'b0 || video_de !== 1'b0) begin
                $display("[ERROR] %s vsync href de in reset expected 000 actual %b%b%b",
                         cur_test, video_vsync, video_href, video_de);
                test_errors++;
                err_count++;
            end
        end
        rst_n = 1'b1;
        wait_output_frame();
        report_test();

        begin_test("timing");
        wait_output_frame();
        if (vs_periods == 0) begin
            $display("%s: no complete vsync period was seen", cur_test);
            test_errors++;
            err_count++;
        end
        report_test();

        begin_test("stitch");
        @(posedge video_vsync);
        send_frames(3'b011, `CAM_V);
        wait_output_frame();
        report_test();

        // only three rows, so camera 2 must stay black
        begin_test("short_frame");
        @(posedge video_vsync);
        send_frames(3'b100, 3);
        wait_output_frame();
        report_test();

        begin_test("refresh");
        @(posedge video_vsync);
        send_frames(3'b101, `CAM_V);
        wait_output_frame();
        report_test();

        $display("tests %0d, failed %0d, pixel checks %0d, errors %0d",
                 test_count, failed_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/cam_capture.sv
`timescale 1ns/1ns
`include "stitch_macros.svh"

module cam_capture (
      input  logic                video_clk
    , input  logic                rst_n
    , input  logic                vsync
    , input  logic                href
    , input  logic                clken
    , input  logic [`PIX_W-1:0]  data
    , input  logic [`ADDR_W-1:0] rd_addr
    , output logic [`PIX_W-1:0]  rd_data
    , output logic                frame_ready
);

    localparam int COL_W = $clog2(`CAM_H);
    localparam int ROW_W = $clog2(`CAM_V);

    // one extra bit so the counters can sit past the frame edge
    logic [COL_W:0]         col_cnt;
    logic [ROW_W:0]         row_cnt;
    logic [`ADDR_W:0]       pix_cnt;

    logic                   href_d;
    logic                   vsync_d;
    logic                   href_fall;
    logic                   vsync_rise;

    logic                   pix_valid;
    logic                   in_window;
    logic                   wr_en;
    logic [`ADDR_W-1:0]     wr_addr;

    logic [`PIX_W-1:0]      frame_mem [0:`CAM_PIX-1];

    assign pix_valid  = href && clken && !vsync;
    assign in_window  = (col_cnt < `CAM_H) && (row_cnt < `CAM_V);
    assign wr_en      = pix_valid && in_window;
    assign wr_addr    = {row_cnt[ROW_W-1:0], col_cnt[COL_W-1:0]};

    assign href_fall  = href_d && !href;
    assign vsync_rise = vsync && !vsync_d;

    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            href_d  <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            href_d  <= href;
            vsync_d <= vsync;
        end
    end

    // column, row and landed-pixel counters
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
            pix_cnt <= '0;
        end else if (vsync_rise) begin
            col_cnt <= '0;
            row_cnt <= '0;
            pix_cnt <= '0;
        end else begin
            if (href_fall && !vsync) begin
                col_cnt <= '0;
                if (row_cnt < `CAM_V) begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else if (pix_valid && (col_cnt < `CAM_H)) begin
                col_cnt <= col_cnt + 1'b1;
            end
            if (wr_en) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // sticky flag set only by a complete frame
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            frame_ready <= 1'b0;
        end else if (vsync_rise && (pix_cnt == `CAM_PIX)) begin
            frame_ready <= 1'b1;
        end
    end

    // frame store with a one clock read
    always_ff @(posedge video_clk) begin
        if (wr_en) begin
            frame_mem[wr_addr] <= data;
        end
        rd_data <= frame_mem[rd_addr];
    end

    // no write lands past the CAM_PIX entries of one frame
    a_wr_in_frame: assert property (
        @(posedge video_clk) disable iff (!rst_n)
        wr_en |-> (pix_cnt < `CAM_PIX)
    );

endmodule

//--- verilog/stitch_macros.svh
`ifndef STITCH_MACROS_SVH
`define STITCH_MACROS_SVH

// horizontal timing in video_clk cycles
`define H_SYNC   2
`define H_BACK   3
`define H_DISP   24
`define H_FRONT  3
`define H_TOTAL  32

// vertical timing in lines
`define V_SYNC   1
`define V_BACK   1
`define V_DISP   4
`define V_FRONT  1
`define V_TOTAL  7

// three camera frames side by side make H_DISP
`define CAM_H    8
`define CAM_V    4
`define NUM_CAM  3

// RGB888
`define PIX_W    24
`define CAM_PIX  32
`define ADDR_W   5

// display coordinate widths
`define X_W      6
`define Y_W      4

`endif

//--- verilog/stitch_pkg.sv
package stitch_pkg;

    // phase of a line or of a frame
    typedef enum logic [1:0] {
        PH_SYNC   = 2'd0,
        PH_BACK   = 2'd1,
        PH_ACTIVE = 2'd2,
        PH_FRONT  = 2'd3
    } timing_phase_t;

endpackage

//--- verilog/stitch_readout.sv
`timescale 1ns/1ns
`include "stitch_macros.svh"

module stitch_readout (
      input  logic                       video_clk
    , input  logic                       rst_n
    , input  stitch_pkg::timing_phase_t  h_phase
    , input  stitch_pkg::timing_phase_t  v_phase
    , input  logic [`X_W-1:0]            pix_x
    , input  logic [`Y_W-1:0]            pix_y
    , input  logic [`PIX_W-1:0]          rd_data0
    , input  logic [`PIX_W-1:0]          rd_data1
    , input  logic [`PIX_W-1:0]          rd_data2
    , input  logic [`NUM_CAM-1:0]        frame_ready
    , output logic [`ADDR_W-1:0]         rd_addr
    , output logic                       video_vsync
    , output logic                       video_href
    , output logic                       video_de
    , output logic [`PIX_W-1:0]          video_data
);

    localparam int COL_W = $clog2(`CAM_H);
    localparam int ROW_W = `ADDR_W - COL_W;

    // CAM_H is a power of two, so slot and column are bit fields of x
    logic [`X_W-COL_W-1:0]  slot;
    logic [COL_W-1:0]       col;
    logic                   active;

    logic [`X_W-COL_W-1:0]  slot_q;
    logic [`NUM_CAM-1:0]    ready_q;

    assign slot    = pix_x[`X_W-1:COL_W];
    assign col     = pix_x[COL_W-1:0];
    assign rd_addr = {pix_y[ROW_W-1:0], col};
    assign active  = (h_phase == stitch_pkg::PH_ACTIVE) &&
                     (v_phase == stitch_pkg::PH_ACTIVE);

    // delay flags by one clock to line up with the store read
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            video_vsync <= 1'b0;
            video_href  <= 1'b0;
            video_de    <= 1'b0;
            ready_q     <= '0;
        end else begin
            video_vsync <= (v_phase == stitch_pkg::PH_SYNC);
            video_href  <= (h_phase == stitch_pkg::PH_SYNC);
            video_de    <= active;
            ready_q     <= frame_ready;
        end
    end

    always_ff @(posedge video_clk) begin
        slot_q <= slot;
    end

    // camera for this third of the line or black when not ready
    always_comb begin
        video_data = '0;
        if (video_de) begin
            case (slot_q)
                0: video_data = ready_q[0] ? rd_data0 : '0;
                1: video_data = ready_q[1] ? rd_data1 : '0;
                2: video_data = ready_q[2] ? rd_data2 : '0;
                default: video_data = '0;
            endcase
        end
    end

    a_slot_in_range: assert property (
        @(posedge video_clk) disable iff (!rst_n)
        video_de |-> (slot_q < `NUM_CAM)
    );

endmodule

//--- verilog/video_stitch_top.sv
`timescale 1ns/1ns
`include "stitch_macros.svh"

module video_stitch_top (
      input  logic               video_clk
    , input  logic               rst_n

    , input  logic               cmos0_vsync
    , input  logic               cmos0_href
    , input  logic               cmos0_clken
    , input  logic [`PIX_W-1:0] cmos0_data

    , input  logic               cmos1_vsync
    , input  logic               cmos1_href
    , input  logic               cmos1_clken
    , input  logic [`PIX_W-1:0] cmos1_data

    , input  logic               cmos2_vsync
    , input  logic               cmos2_href
    , input  logic               cmos2_clken
    , input  logic [`PIX_W-1:0] cmos2_data

    , output logic               video_vsync
    , output logic               video_href
    , output logic               video_de
    , output logic [`PIX_W-1:0] video_data
);

    logic                       cam_vsync   [`NUM_CAM];
    logic                       cam_href    [`NUM_CAM];
    logic                       cam_clken   [`NUM_CAM];
    logic [`PIX_W-1:0]          cam_data    [`NUM_CAM];
    logic [`PIX_W-1:0]          cam_rd_data [`NUM_CAM];
    logic [`NUM_CAM-1:0]        cam_ready;

    logic [`ADDR_W-1:0]         rd_addr;
    stitch_pkg::timing_phase_t  h_phase;
    stitch_pkg::timing_phase_t  v_phase;
    logic [`X_W-1:0]            pix_x;
    logic [`Y_W-1:0]            pix_y;

    // gather camera ports for the capture loop
    assign cam_vsync[0] = cmos0_vsync;
    assign cam_href[0]  = cmos0_href;
    assign cam_clken[0] = cmos0_clken;
    assign cam_data[0]  = cmos0_data;

    assign cam_vsync[1] = cmos1_vsync;
    assign cam_href[1]  = cmos1_href;
    assign cam_clken[1] = cmos1_clken;
    assign cam_data[1]  = cmos1_data;

    assign cam_vsync[2] = cmos2_vsync;
    assign cam_href[2]  = cmos2_href;
    assign cam_clken[2] = cmos2_clken;
    assign cam_data[2]  = cmos2_data;

    generate
        for (genvar i = 0; i < `NUM_CAM; i++) begin : g_cam
            cam_capture u_cam_capture (
                  .video_clk   (video_clk)
                , .rst_n       (rst_n)
                , .vsync       (cam_vsync[i])
                , .href        (cam_href[i])
                , .clken       (cam_clken[i])
                , .data        (cam_data[i])
                , .rd_addr     (rd_addr)
                , .rd_data     (cam_rd_data[i])
                , .frame_ready (cam_ready[i])
            );
        end
    endgenerate

    video_timing_gen u_video_timing_gen (
          .video_clk (video_clk)
        , .rst_n     (rst_n)
        , .h_phase   (h_phase)
        , .v_phase   (v_phase)
        , .pix_x     (pix_x)
        , .pix_y     (pix_y)
    );

    stitch_readout u_stitch_readout (
          .video_clk   (video_clk)
        , .rst_n       (rst_n)
        , .h_phase     (h_phase)
        , .v_phase     (v_phase)
        , .pix_x       (pix_x)
        , .pix_y       (pix_y)
        , .rd_data0    (cam_rd_data[0])
        , .rd_data1    (cam_rd_data[1])
        , .rd_data2    (cam_rd_data[2])
        , .frame_ready (cam_ready)
        , .rd_addr     (rd_addr)
        , .video_vsync (video_vsync)
        , .video_href  (video_href)
        , .video_de    (video_de)
        , .video_data  (video_data)
    );

endmodule

//--- verilog/video_timing_gen.sv
`timescale 1ns/1ns
`include "stitch_macros.svh"

module video_timing_gen (
      input  logic                       video_clk
    , input  logic                       rst_n
    , output stitch_pkg::timing_phase_t  h_phase
    , output stitch_pkg::timing_phase_t  v_phase
    , output logic [`X_W-1:0]            pix_x
    , output logic [`Y_W-1:0]            pix_y
);

    // counts within the current phase, not within the whole line
    logic [`X_W-1:0]  h_cnt;
    logic [`Y_W-1:0]  v_cnt;
    logic             h_done;
    logic             v_done;
    logic             line_end;

    function automatic stitch_pkg::timing_phase_t next_phase(
        input stitch_pkg::timing_phase_t ph
    );
        case (ph)
            stitch_pkg::PH_SYNC:   next_phase = stitch_pkg::PH_BACK;
            stitch_pkg::PH_BACK:   next_phase = stitch_pkg::PH_ACTIVE;
            stitch_pkg::PH_ACTIVE: next_phase = stitch_pkg::PH_FRONT;
            default:               next_phase = stitch_pkg::PH_SYNC;
        endcase
    endfunction

    // last clock of each horizontal phase
    always_comb begin
        case (h_phase)
            stitch_pkg::PH_SYNC:   h_done = (h_cnt == `H_SYNC - 1);
            stitch_pkg::PH_BACK:   h_done = (h_cnt == `H_BACK - 1);
            stitch_pkg::PH_ACTIVE: h_done = (h_cnt == `H_DISP - 1);
            default:               h_done = (h_cnt == `H_FRONT - 1);
        endcase
    end

    // last line of each vertical phase
    always_comb begin
        case (v_phase)
            stitch_pkg::PH_SYNC:   v_done = (v_cnt == `V_SYNC - 1);
            stitch_pkg::PH_BACK:   v_done = (v_cnt == `V_BACK - 1);
            stitch_pkg::PH_ACTIVE: v_done = (v_cnt == `V_DISP - 1);
            default:               v_done = (v_cnt == `V_FRONT - 1);
        endcase
    end

    assign line_end = h_done && (h_phase == stitch_pkg::PH_FRONT);

    // reset parks at the start of hsync on the first vsync line
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            h_phase <= stitch_pkg::PH_SYNC;
            h_cnt   <= '0;
        end else if (h_done) begin
            h_phase <= next_phase(h_phase);
            h_cnt   <= '0;
        end else begin
            h_cnt   <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            v_phase <= stitch_pkg::PH_SYNC;
            v_cnt   <= '0;
        end else if (line_end) begin
            if (v_done) begin
                v_phase <= next_phase(v_phase);
                v_cnt   <= '0;
            end else begin
                v_cnt   <= v_cnt + 1'b1;
            end
        end
    end

    assign pix_x = (h_phase == stitch_pkg::PH_ACTIVE) ? h_cnt : '0;
    assign pix_y = (v_phase == stitch_pkg::PH_ACTIVE) ? v_cnt : '0;

    a_coord_in_area: assert property (
        @(posedge video_clk) disable iff (!rst_n)
        (h_phase == stitch_pkg::PH_ACTIVE && v_phase == stitch_pkg::PH_ACTIVE)
            |-> (pix_x < `H_DISP && pix_y < `V_DISP)
    );

endmodule
